// File: decoder_pkg.sv
package decoder_pkg;

    // Global stage, driven by the environment into every unit and link
    localparam int STAGE_WIDTH = 3;

    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 3'd0, // Hold everything
        STAGE_CLEAR               = 3'd1, // Latch defects, restart growth and roots
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_MEASUREMENT_LOADING = 3'd6  // Shift one round in per cycle
    } stage_t;

    // Link slots of a processing unit
    localparam int NEIGHBOR_COUNT = 4;

    localparam int NEIGHBOR_IDX_WEST = 0; // Column - 1
    localparam int NEIGHBOR_IDX_EAST = 1; // Column + 1
    localparam int NEIGHBOR_IDX_DOWN = 2; // Previous round
    localparam int NEIGHBOR_IDX_UP   = 3; // Next round

    // Bits needed to index count items, never less than one
    function automatic int field_width(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

    // Bits needed to hold values 0 up to max_value
    function automatic int value_width(input int max_value);
        return field_width(max_value + 1);
    endfunction

endpackage

// File: processing_unit.sv
`timescale 1ns/1ns

module processing_unit #(
    parameter int ADDRESS_WIDTH = 4,
    parameter int ADDRESS       = 0
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  decoder_pkg::stage_t        global_stage_i,

    input  logic                       measurement_i,
    output logic                       measurement_o,

    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0] neighbor_fully_grown_i,
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0][ADDRESS_WIDTH-1:0] neighbor_root_i,
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0] neighbor_boundary_reached_i,
    input  logic                       boundary_grown_i,

    output logic                       defect_o,
    output logic [ADDRESS_WIDTH-1:0]   root_o,
    output logic                       boundary_reached_o,
    output logic                       busy_o
);

    localparam logic [ADDRESS_WIDTH-1:0] OWN_ADDRESS = ADDRESS_WIDTH'(ADDRESS);

    logic                     measurement_q; // Shift register stage of the round chain
    logic                     defect_q;
    logic [ADDRESS_WIDTH-1:0] root_q;
    logic                     boundary_reached_q;
    logic                     busy_q;

    logic [ADDRESS_WIDTH-1:0] root_next;
    logic                     boundary_next;
    logic                     merge_change;

    // Smallest root seen across grown links, and boundary contact
    // spreading one hop per merge cycle
    always_comb begin
        root_next     = root_q;
        boundary_next = boundary_reached_q | boundary_grown_i;
        for (int n = 0; n < decoder_pkg::NEIGHBOR_COUNT; n++) begin
            if (neighbor_fully_grown_i[n]) begin
                if (neighbor_root_i[n] < root_next) begin
                    root_next = neighbor_root_i[n];
                end
                boundary_next = boundary_next | neighbor_boundary_reached_i[n];
            end
        end
    end

    assign merge_change = (root_next != root_q) || (boundary_next != boundary_reached_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            measurement_q      <= 1'b0;
            defect_q           <= 1'b0;
            root_q             <= OWN_ADDRESS;
            boundary_reached_q <= 1'b0;
            busy_q             <= 1'b0;
        end else begin
            case (global_stage_i)
                decoder_pkg::STAGE_MEASUREMENT_LOADING: begin
                    measurement_q <= measurement_i; // Take the round from above
                    busy_q        <= 1'b0;
                end
                decoder_pkg::STAGE_CLEAR: begin
                    defect_q           <= measurement_q;
                    root_q             <= OWN_ADDRESS; // Every unit starts alone
                    boundary_reached_q <= 1'b0;
                    busy_q             <= 1'b0;
                end
                decoder_pkg::STAGE_MERGE: begin
                    root_q             <= root_next;
                    boundary_reached_q <= boundary_next;
                    busy_q             <= merge_change; // Low once the cluster settles
                end
                decoder_pkg::STAGE_GROW: begin
                    busy_q <= 1'b0;
                end
                default: begin
                    // Idle holds all state
                end
            endcase
        end
    end

    assign measurement_o      = measurement_q;
    assign defect_o           = defect_q;
    assign root_o             = root_q;
    assign boundary_reached_o = boundary_reached_q;
    assign busy_o             = busy_q;

endmodule

// File: neighbor_link.sv
`timescale 1ns/1ns

module neighbor_link #(
    parameter int ENDPOINTS  = 2,
    parameter int MAX_WEIGHT = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  decoder_pkg::stage_t  global_stage_i,
    input  logic [ENDPOINTS-1:0] odd_i,
    output logic                 fully_grown_o
);

    localparam int GROWTH_WIDTH = decoder_pkg::value_width(MAX_WEIGHT);
    localparam int SUM_WIDTH    = GROWTH_WIDTH + 2; // Room for two odd endpoints

    localparam logic [GROWTH_WIDTH-1:0] FULL_WEIGHT = GROWTH_WIDTH'(MAX_WEIGHT);

    logic [GROWTH_WIDTH-1:0] growth_q;
    logic [1:0]              odd_count;
    logic [SUM_WIDTH-1:0]    growth_sum;

    // Each odd endpoint pushes the edge by one unit
    always_comb begin
        odd_count = 2'd0;
        for (int e = 0; e < ENDPOINTS; e++) begin
            odd_count = odd_count + {1'b0, odd_i[e]};
        end
    end

    assign growth_sum    = SUM_WIDTH'(growth_q) + SUM_WIDTH'(odd_count);
    assign fully_grown_o = (growth_q == FULL_WEIGHT);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            growth_q <= '0;
        end else begin
            case (global_stage_i)
                decoder_pkg::STAGE_CLEAR: begin
                    growth_q <= '0;
                end
                decoder_pkg::STAGE_GROW: begin
                    if (!fully_grown_o) begin
                        if (growth_sum >= SUM_WIDTH'(MAX_WEIGHT)) begin
                            growth_q <= FULL_WEIGHT; // Saturate
                        end else begin
                            growth_q <= growth_sum[GROWTH_WIDTH-1:0];
                        end
                    end
                end
                default: begin
                    // Other stages leave growth alone
                end
            endcase
        end
    end

endmodule

// File: cluster_parity.sv
`timescale 1ns/1ns

module cluster_parity #(
    parameter int PU_COUNT      = 12,
    parameter int ADDRESS_WIDTH = 4
) (
    input  logic [PU_COUNT*ADDRESS_WIDTH-1:0] roots_i,
    input  logic [PU_COUNT-1:0]               defects_i,
    input  logic [PU_COUNT-1:0]               boundary_reached_i,
    output logic [PU_COUNT-1:0]               odd_o
);

    // One comparator row per unit, every unit with the same root
    // belongs to the same cluster
    for (genvar u = 0; u < PU_COUNT; u++) begin : parity_u
        logic [ADDRESS_WIDTH-1:0] own_root;
        logic                     defect_parity;
        logic                     boundary_touched;

        assign own_root = roots_i[u*ADDRESS_WIDTH +: ADDRESS_WIDTH];

        always_comb begin
            defect_parity    = 1'b0;
            boundary_touched = 1'b0;
            for (int m = 0; m < PU_COUNT; m++) begin
                if (roots_i[m*ADDRESS_WIDTH +: ADDRESS_WIDTH] == own_root) begin
                    defect_parity    = defect_parity ^ defects_i[m];
                    boundary_touched = boundary_touched | boundary_reached_i[m];
                end
            end
        end

        // A cluster that reached a grown boundary can absorb any parity
        assign odd_o[u] = defect_parity & ~boundary_touched;
    end

endmodule

// File: decoding_graph.sv
`timescale 1ns/1ns

module decoding_graph #(
    parameter int GRID_WIDTH_X = 4,
    parameter int GRID_WIDTH_U = 3,
    parameter int MAX_WEIGHT   = 2,
    localparam int X_BIT_WIDTH   = decoder_pkg::field_width(GRID_WIDTH_X),
    localparam int U_BIT_WIDTH   = decoder_pkg::field_width(GRID_WIDTH_U),
    localparam int ADDRESS_WIDTH = X_BIT_WIDTH + U_BIT_WIDTH, // Round field above column
    localparam int PU_COUNT      = GRID_WIDTH_X * GRID_WIDTH_U
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  decoder_pkg::stage_t               global_stage_i,
    input  logic [GRID_WIDTH_X-1:0]           measurements_i,
    output logic [PU_COUNT*ADDRESS_WIDTH-1:0] roots_o,
    output logic [PU_COUNT-1:0]               odd_clusters_o,
    output logic [PU_COUNT-1:0]               busy_o
);

    localparam int NC     = decoder_pkg::NEIGHBOR_COUNT;
    localparam int EW_ROW = GRID_WIDTH_X + 1; // East-west links per round, two at the boundary

    logic [PU_COUNT-1:0]                     measurement_chain;
    logic [PU_COUNT-1:0]                     defects;
    logic [PU_COUNT-1:0]                     boundary_reached;
    logic [GRID_WIDTH_U*EW_ROW-1:0]          ew_grown;
    logic [(GRID_WIDTH_U-1)*GRID_WIDTH_X-1:0] ud_grown; // Between round k-1 and k

    // Unit grid, unit index is round * GRID_WIDTH_X + column
    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : pu_k
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : pu_i
            localparam int IDX = k * GRID_WIDTH_X + i;

            wire                              measurement_in;
            wire                              boundary_grown;
            wire [NC-1:0]                     neighbor_fully_grown;
            wire [NC-1:0][ADDRESS_WIDTH-1:0]  neighbor_root;
            wire [NC-1:0]                     neighbor_boundary_reached;

            if (k == GRID_WIDTH_U - 1) begin : g_meas_top
                assign measurement_in = measurements_i[i]; // New rounds enter here
            end else begin : g_meas_chain
                assign measurement_in = measurement_chain[IDX + GRID_WIDTH_X];
            end

            if (i > 0) begin : g_west
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_WEST] = ew_grown[k*EW_ROW + i];
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_WEST] =
                    roots_o[(IDX-1)*ADDRESS_WIDTH +: ADDRESS_WIDTH];
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_WEST] =
                    boundary_reached[IDX-1];
            end else begin : g_west_none
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_WEST]      = 1'b0;
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_WEST]             = '0;
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_WEST] = 1'b0;
            end

            if (i < GRID_WIDTH_X - 1) begin : g_east
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_EAST] =
                    ew_grown[k*EW_ROW + i + 1];
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_EAST] =
                    roots_o[(IDX+1)*ADDRESS_WIDTH +: ADDRESS_WIDTH];
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_EAST] =
                    boundary_reached[IDX+1];
            end else begin : g_east_none
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_EAST]      = 1'b0;
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_EAST]             = '0;
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_EAST] = 1'b0;
            end

            if (k > 0) begin : g_down
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_DOWN] =
                    ud_grown[(k-1)*GRID_WIDTH_X + i];
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_DOWN] =
                    roots_o[(IDX-GRID_WIDTH_X)*ADDRESS_WIDTH +: ADDRESS_WIDTH];
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_DOWN] =
                    boundary_reached[IDX-GRID_WIDTH_X];
            end else begin : g_down_none // Bottom round has no time boundary
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_DOWN]      = 1'b0;
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_DOWN]             = '0;
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_DOWN] = 1'b0;
            end

            if (k < GRID_WIDTH_U - 1) begin : g_up
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_UP] =
                    ud_grown[k*GRID_WIDTH_X + i];
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_UP] =
                    roots_o[(IDX+GRID_WIDTH_X)*ADDRESS_WIDTH +: ADDRESS_WIDTH];
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_UP] =
                    boundary_reached[IDX+GRID_WIDTH_X];
            end else begin : g_up_none
                assign neighbor_fully_grown[decoder_pkg::NEIGHBOR_IDX_UP]      = 1'b0;
                assign neighbor_root[decoder_pkg::NEIGHBOR_IDX_UP]             = '0;
                assign neighbor_boundary_reached[decoder_pkg::NEIGHBOR_IDX_UP] = 1'b0;
            end

            // Spatial boundary links sit at the first and last column only
            assign boundary_grown = ((i == 0) ? ew_grown[k*EW_ROW] : 1'b0)
                                  | ((i == GRID_WIDTH_X - 1) ? ew_grown[k*EW_ROW + GRID_WIDTH_X] : 1'b0);

            processing_unit #(
                .ADDRESS_WIDTH (ADDRESS_WIDTH),
                .ADDRESS       ((k << X_BIT_WIDTH) + i)
            ) pu (
                .clk_i                       (clk_i),
                .rst_n_i                     (rst_n_i),
                .global_stage_i              (global_stage_i),
                .measurement_i               (measurement_in),
                .measurement_o               (measurement_chain[IDX]),
                .neighbor_fully_grown_i      (neighbor_fully_grown),
                .neighbor_root_i             (neighbor_root),
                .neighbor_boundary_reached_i (neighbor_boundary_reached),
                .boundary_grown_i            (boundary_grown),
                .defect_o                    (defects[IDX]),
                .root_o                      (roots_o[IDX*ADDRESS_WIDTH +: ADDRESS_WIDTH]),
                .boundary_reached_o          (boundary_reached[IDX]),
                .busy_o                      (busy_o[IDX])
            );
        end
    end

    // East-west links, index i joins column i-1 to column i
    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : ew_k
        for (genvar i = 0; i <= GRID_WIDTH_X; i++) begin : ew_i
            if (i == 0 || i == GRID_WIDTH_X) begin : g_boundary
                neighbor_link #(
                    .ENDPOINTS  (1),
                    .MAX_WEIGHT (MAX_WEIGHT)
                ) link (
                    .clk_i          (clk_i),
                    .rst_n_i        (rst_n_i),
                    .global_stage_i (global_stage_i),
                    .odd_i          (odd_clusters_o[k*GRID_WIDTH_X + ((i == 0) ? 0 : i - 1)]),
                    .fully_grown_o  (ew_grown[k*EW_ROW + i])
                );
            end else begin : g_internal
                neighbor_link #(
                    .ENDPOINTS  (2),
                    .MAX_WEIGHT (MAX_WEIGHT)
                ) link (
                    .clk_i          (clk_i),
                    .rst_n_i        (rst_n_i),
                    .global_stage_i (global_stage_i),
                    .odd_i          ({odd_clusters_o[k*GRID_WIDTH_X + i],
                                      odd_clusters_o[k*GRID_WIDTH_X + i - 1]}),
                    .fully_grown_o  (ew_grown[k*EW_ROW + i])
                );
            end
        end
    end

    // Time links between consecutive rounds
    for (genvar k = 1; k < GRID_WIDTH_U; k++) begin : ud_k
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : ud_i
            neighbor_link #(
                .ENDPOINTS  (2),
                .MAX_WEIGHT (MAX_WEIGHT)
            ) link (
                .clk_i          (clk_i),
                .rst_n_i        (rst_n_i),
                .global_stage_i (global_stage_i),
                .odd_i          ({odd_clusters_o[k*GRID_WIDTH_X + i],
                                  odd_clusters_o[(k-1)*GRID_WIDTH_X + i]}),
                .fully_grown_o  (ud_grown[(k-1)*GRID_WIDTH_X + i])
            );
        end
    end

    cluster_parity #(
        .PU_COUNT      (PU_COUNT),
        .ADDRESS_WIDTH (ADDRESS_WIDTH)
    ) parity (
        .roots_i            (roots_o),
        .defects_i          (defects),
        .boundary_reached_i (boundary_reached),
        .odd_o              (odd_clusters_o)
    );

endmodule

// File: decoding_graph_sva.sv
`timescale 1ns/1ns

module decoding_graph_sva #(
    parameter int ADDRESS_WIDTH = 4,
    parameter int ADDRESS       = 0
) (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input decoder_pkg::stage_t      global_stage_i,
    input logic [ADDRESS_WIDTH-1:0] root_i,
    input logic                     busy_i
);

    int unsigned violations = 0; // Failed assertions in this unit

    busy_only_in_merge: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        global_stage_i != decoder_pkg::STAGE_MERGE |-> !busy_i)
        else begin
            $error("Unit %0d busy outside the merge stage", ADDRESS);
            violations++;
        end

    // Roots only move toward smaller addresses
    root_not_above_own: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        root_i <= ADDRESS_WIDTH'(ADDRESS))
        else begin
            $error("Unit %0d root %0d above its own address", ADDRESS, root_i);
            violations++;
        end

    busy_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !busy_i)
        else begin
            $error("Unit %0d busy right after reset", ADDRESS);
            violations++;
        end

endmodule

bind processing_unit decoding_graph_sva #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .ADDRESS       (ADDRESS)
) unit_sva (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .global_stage_i (global_stage_i),
    .root_i         (root_o),
    .busy_i         (busy_o)
);

// File: tb_decoding_graph_model.svh
`ifndef TB_DECODING_GRAPH_MODEL_SVH
`define TB_DECODING_GRAPH_MODEL_SVH

// Per round X+1 east-west links with the boundary links at offsets 0 and X
bit model_defect [PU_COUNT];
bit model_odd    [PU_COUNT];
int model_root   [PU_COUNT];
int ew_growth    [GRID_WIDTH_U*(GRID_WIDTH_X+1)];
int ud_growth    [(GRID_WIDTH_U-1)*GRID_WIDTH_X]; // Index j joins unit j to unit j+X

// Offset 0 selects the west link of unit u and offset 1 the east link
function automatic int ew_index(input int u, input int offset);
    return (u / GRID_WIDTH_X) * (GRID_WIDTH_X + 1) + u % GRID_WIDTH_X + offset;
endfunction

function automatic int step_growth(input int growth, input int count);
    return (growth + count > MAX_WEIGHT) ? MAX_WEIGHT : growth + count;
endfunction

// Grown internal link from unit a to the unit east of it or one round up
function automatic bit units_joined(input int a, input int b);
    if (b == a + 1 && a % GRID_WIDTH_X != GRID_WIDTH_X - 1) begin
        return ew_growth[ew_index(a, 1)] == MAX_WEIGHT;
    end
    return b == a + GRID_WIDTH_X && ud_growth[a] == MAX_WEIGHT;
endfunction

function automatic bit touches_boundary(input int u);
    return (u % GRID_WIDTH_X == 0 && ew_growth[ew_index(u, 0)] == MAX_WEIGHT)
        || (u % GRID_WIDTH_X == GRID_WIDTH_X - 1 && ew_growth[ew_index(u, 1)] == MAX_WEIGHT);
endfunction

// Smallest address per component, then parity of each cluster
function automatic void model_settle();
    bit moved;
    bit parity;
    bit bound;
    int lo;
    foreach (model_root[u]) begin
        model_root[u] = ((u / GRID_WIDTH_X) << X_FIELD) + u % GRID_WIDTH_X;
    end
    do begin
        moved = 1'b0;
        for (int a = 0; a < PU_COUNT; a++) begin
            for (int b = a + 1; b < PU_COUNT; b++) begin
                if (units_joined(a, b) && model_root[a] != model_root[b]) begin
                    lo = (model_root[a] < model_root[b]) ? model_root[a] : model_root[b];
                    model_root[a] = lo;
                    model_root[b] = lo;
                    moved = 1'b1;
                end
            end
        end
    end while (moved);
    foreach (model_odd[u]) begin
        parity = 1'b0;
        bound  = 1'b0;
        for (int v = 0; v < PU_COUNT; v++) begin
            if (model_root[v] == model_root[u]) begin
                parity ^= model_defect[v];
                bound  |= touches_boundary(v);
            end
        end
        model_odd[u] = parity & ~bound;
    end
endfunction

// First loaded round ends in round 0
function automatic void model_clear();
    foreach (model_defect[u]) begin
        model_defect[u] = loaded_rounds[u / GRID_WIDTH_X][u % GRID_WIDTH_X];
    end
    foreach (ew_growth[e]) begin
        ew_growth[e] = 0;
    end
    foreach (ud_growth[j]) begin
        ud_growth[j] = 0;
    end
    model_settle();
endfunction

function automatic void model_grow();
    int k;
    int i;
    int count;
    foreach (ew_growth[e]) begin
        k     = e / (GRID_WIDTH_X + 1);
        i     = e % (GRID_WIDTH_X + 1);
        count = ((i > 0) ? model_odd[e - k - 1] : 0) + ((i < GRID_WIDTH_X) ? model_odd[e - k] : 0);
        ew_growth[e] = step_growth(ew_growth[e], count);
    end
    foreach (ud_growth[j]) begin
        count        = int'(model_odd[j]) + int'(model_odd[j + GRID_WIDTH_X]);
        ud_growth[j] = step_growth(ud_growth[j], count);
    end
endfunction

function automatic bit model_has_odd();
    foreach (model_odd[u]) begin
        if (model_odd[u]) return 1'b1;
    end
    return 1'b0;
endfunction

`endif

// File: tb_decoding_graph.sv
`timescale 1ns/1ns

module tb_decoding_graph;

    localparam int GRID_WIDTH_X  = 4;
    localparam int GRID_WIDTH_U  = 3;
    localparam int MAX_WEIGHT    = 2;
    localparam int PU_COUNT      = GRID_WIDTH_X * GRID_WIDTH_U;
    localparam int X_FIELD       = (GRID_WIDTH_X > 1) ? $clog2(GRID_WIDTH_X) : 1;
    localparam int U_FIELD       = (GRID_WIDTH_U > 1) ? $clog2(GRID_WIDTH_U) : 1;
    localparam int ADDRESS_WIDTH = X_FIELD + U_FIELD;
    localparam int TRIALS        = 20;
    localparam int GROW_STEPS    = 6;
    localparam int MERGE_LIMIT   = PU_COUNT + 2;
    localparam int CYCLE_LIMIT   = TRIALS * (GRID_WIDTH_U + 1 + GROW_STEPS * MERGE_LIMIT) + 100;

    logic                              clk = 1'b0;
    logic                              rst_n;
    decoder_pkg::stage_t               global_stage;
    logic [GRID_WIDTH_X-1:0]           measurements;
    logic [PU_COUNT*ADDRESS_WIDTH-1:0] roots;
    logic [PU_COUNT-1:0]               odd_clusters;
    logic [PU_COUNT-1:0]               busy;
    logic [GRID_WIDTH_X-1:0]           loaded_rounds [GRID_WIDTH_U];
    wire  [31:0]                       sva_failures [PU_COUNT];
    int                                seed = 78838;
    int                                cycle_count = 0;

    `include "tb_decoding_graph_model.svh"

    decoding_graph #(
        .GRID_WIDTH_X (GRID_WIDTH_X),
        .GRID_WIDTH_U (GRID_WIDTH_U),
        .MAX_WEIGHT   (MAX_WEIGHT)
    ) decoding_graph_inst (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .global_stage_i (global_stage),
        .measurements_i (measurements),
        .roots_o        (roots),
        .odd_clusters_o (odd_clusters),
        .busy_o         (busy)
    );

    always #20 clk = ~clk;

    // Failure counts of the checkers bound into each unit
    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : sva_k
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : sva_i
            assign sva_failures[k*GRID_WIDTH_X + i] =
                decoding_graph_inst.pu_k[k].pu_i[i].pu.unit_sva.violations;
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    // Inputs change 2 ns after the edge, outputs are read at the same point
    task automatic run_cycle(input decoder_pkg::stage_t stage,
                             input logic [GRID_WIDTH_X-1:0] meas);
        global_stage = stage;
        measurements = meas;
        @(posedge clk);
        #2;
    endtask

    task automatic check_state(input string name);
        logic [PU_COUNT-1:0] odd_exp;
        int                  got;
        for (int u = 0; u < PU_COUNT; u++) begin
            got        = int'(roots[u*ADDRESS_WIDTH +: ADDRESS_WIDTH]);
            odd_exp[u] = model_odd[u];
            assert (got == model_root[u]) else begin
                $display("ERR %s root of unit %0d expected %0d actual %0d",
                         name, u, model_root[u], got);
                abort_run();
            end
        end
        assert (odd_clusters == odd_exp) else begin
            $display("ERR %s odd flags expected %b actual %b", name, odd_exp, odd_clusters);
            abort_run();
        end
    endtask

    task automatic maybe_idle(input string name);
        logic [PU_COUNT*ADDRESS_WIDTH-1:0] held_roots;
        logic [PU_COUNT-1:0]               held_odd;
        held_roots = roots;
        held_odd   = odd_clusters;
        if (($random(seed) & 3) == 0) begin
            run_cycle(decoder_pkg::STAGE_IDLE, '0);
            assert (roots == held_roots && odd_clusters == held_odd) else begin
                $display("ERR %s idle expected %h %b actual %h %b",
                         name, held_roots, held_odd, roots, odd_clusters);
                abort_run();
            end
        end
    endtask

    initial begin
        int merge_cycles;
        int failures;
        rst_n        = 1'b0;
        global_stage = decoder_pkg::STAGE_IDLE;
        measurements = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        model_settle(); // No defects and no growth yet
        assert (busy == '0) else begin
            $display("ERR reset busy expected %b actual %b", {PU_COUNT{1'b0}}, busy);
            abort_run();
        end
        check_state("reset");
        for (int t = 0; t < TRIALS; t++) begin
            for (int r = 0; r < GRID_WIDTH_U; r++) begin
                loaded_rounds[r] = $random(seed);
                run_cycle(decoder_pkg::STAGE_MEASUREMENT_LOADING, loaded_rounds[r]);
            end
            run_cycle(decoder_pkg::STAGE_CLEAR, '0);
            model_clear();
            check_state($sformatf("clear trial %0d", t));
            maybe_idle($sformatf("clear trial %0d", t));
            for (int g = 0; g < GROW_STEPS && model_has_odd(); g++) begin
                run_cycle(decoder_pkg::STAGE_GROW, '0);
                model_grow();
                merge_cycles = 0;
                do begin
                    run_cycle(decoder_pkg::STAGE_MERGE, '0);
                    merge_cycles++;
                end while (busy != '0 && merge_cycles < MERGE_LIMIT);
                assert (busy == '0) else begin
                    $display("Merge still busy after %0d cycles in trial %0d", MERGE_LIMIT, t);
                    abort_run();
                end
                model_settle();
                check_state($sformatf("merge trial %0d step %0d", t, g));
                maybe_idle($sformatf("merge trial %0d step %0d", t, g));
            end
        end
        failures = 0;
        for (int u = 0; u < PU_COUNT; u++) begin
            failures += sva_failures[u];
        end
        if (failures == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", failures);
            abort_run();
        end
    end

endmodule

// File: decoding_graph.f
+incdir+.
decoder_pkg.sv
processing_unit.sv
neighbor_link.sv
cluster_parity.sv
decoding_graph.sv
decoding_graph_sva.sv
tb_decoding_graph.sv
